// File: files.f
hdl/noc_csr_pkg.sv
hdl/csr_regfile.sv
hdl/vc_rd_buffers.sv
hdl/irq_combiner.sv
hdl/noc_csr_top.sv
tests/tb_noc_csr.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f files.f \
		--top-module tb_noc_csr -Mdir obj_dir -o Vtb_noc_csr
	./obj_dir/Vtb_noc_csr | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_noc_csr.sv
/*
  Directed testbench for the network interface status and interrupt block.
  Covers register accesses, flit traffic and every interrupt mode, using
  one queue per channel as the reference model of the read buffers.
*/
module tb_noc_csr import noc_csr_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 4;
  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 400;

  logic                  clk_axi;
  logic                  arst_axi;
  logic                  csr_req_i;
  logic                  csr_wr_i;
  logic [31:0]           csr_addr_i;
  logic [31:0]           csr_wdata_i;
  logic                  csr_ack_o;
  logic [31:0]           csr_rdata_o;
  logic                  csr_err_o;
  logic                  in_valid_i;
  logic [VC_W-1:0]       in_vc_i;
  logic [FLIT_W-1:0]     in_data_i;
  logic                  in_ready_o;
  logic [VC_W-1:0]       out_vc_i;
  logic                  out_ready_i;
  logic                  out_valid_o;
  logic [FLIT_W-1:0]     out_data_o;
  logic [N_VIRT_CHN-1:0] irq_vcs_o;
  logic                  irq_trig_o;

  // Expected buffer contents and the interrupt setup last written.
  logic [31:0] model_q [N_VIRT_CHN][$];
  irq_mode_t   cur_mode;
  logic [31:0] cur_mask;
  integer      seed;
  int          err_count;
  int          check_count;
  int          test_start_errs;

  noc_csr_top #(.ROUTER_X_ID(2), .ROUTER_Y_ID(1)) DUT (.*);

  initial begin
    clk_axi = 1'b0;
    forever #(CLK_PERIOD / 2) clk_axi = ~clk_axi;
  end

  // Each test has a fixed budget of cycles.
  // A stuck handshake ends the run here.
  initial begin
    #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within the allowed time.");
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %-16s done with %0d errors", name, err_count - test_start_errs);
    test_start_errs = err_count;
  endtask

  function automatic logic [31:0] reg_addr(input logic [7:0] off);
    return CSR_BASE_ADDR + 32'(off);
  endfunction

  // Interrupts as the mode rules give them for the current model contents.
  function automatic logic [N_VIRT_CHN-1:0] expected_irq();
    logic [N_VIRT_CHN-1:0] v;
    int n;
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      n = model_q[i].size();
      case (cur_mode)
        IRQ_EMPTY_MASKED: v[i] = (n != 0) && cur_mask[i];
        IRQ_FULL_MASKED:  v[i] = (n == BUFF_DEPTH) && cur_mask[i];
        IRQ_OCUP_CMP:     v[i] = (32'(n) >= cur_mask);
        default:          v[i] = (n != 0);
      endcase
    end
    return v;
  endfunction

  function automatic logic [31:0] nonempty_map();
    logic [31:0] m;
    m = '0;
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      m[i] = (model_q[i].size() != 0);
    end
    return m;
  endfunction

  // One complete four-phase exchange, sampled on falling edges.
  task automatic csr_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk_axi);
    csr_req_i   <= 1'b1;
    csr_wr_i    <= wr;
    csr_addr_i  <= addr;
    csr_wdata_i <= wdata;
    @(negedge clk_axi);
    while (!csr_ack_o) @(negedge clk_axi);
    rdata = csr_rdata_o;
    err   = csr_err_o;
    @(posedge clk_axi);
    csr_req_i <= 1'b0;
    @(negedge clk_axi);
    while (csr_ack_o) @(negedge clk_axi);
  endtask

  task automatic csr_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    csr_access(1'b0, addr, '0, data, err);
  endtask

  task automatic csr_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] rdata;
    csr_access(1'b1, addr, data, rdata, err);
    // Write responses always carry zero data.
    check_value("csr_rdata_o", rdata, '0);
  endtask

  task automatic check_read(input logic [7:0] off, input logic [31:0] exp_data,
                            input logic exp_err);
    logic [31:0] data;
    logic        err;
    csr_read(reg_addr(off), data, err);
    check_value("csr_rdata_o", data, exp_data);
    check_value("csr_err_o", 32'(err), 32'(exp_err));
  endtask

  task automatic check_write(input logic [7:0] off, input logic [31:0] data,
                             input logic exp_err);
    logic err;
    csr_write(reg_addr(off), data, err);
    check_value("csr_err_o", 32'(err), 32'(exp_err));
  endtask

  task automatic set_irq_config(input irq_mode_t mode, input logic [31:0] mask);
    check_write(IRQ_RD_MUX, 32'(mode), 1'b0);
    check_write(IRQ_RD_MASK, mask, 1'b0);
    cur_mode = mode;
    cur_mask = mask;
  endtask

  task automatic push_flit(input int vc);
    logic [31:0] data;
    data = $random(seed);
    @(posedge clk_axi);
    in_valid_i <= 1'b1;
    in_vc_i    <= VC_W'(vc);
    in_data_i  <= data;
    @(negedge clk_axi);
    while (!in_ready_o) @(negedge clk_axi);
    // The flit is taken on this edge.
    @(posedge clk_axi);
    in_valid_i <= 1'b0;
    model_q[vc].push_back(data);
  endtask

  task automatic pop_flit(input int vc);
    logic [31:0] expected;
    @(posedge clk_axi);
    out_vc_i    <= VC_W'(vc);
    out_ready_i <= 1'b1;
    @(negedge clk_axi);
    while (!out_valid_o) @(negedge clk_axi);
    expected = model_q[vc].pop_front();
    check_value("out_data_o", out_data_o, expected);
    @(posedge clk_axi);
    out_ready_i <= 1'b0;
  endtask

  task automatic drain_all();
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      while (model_q[i].size() != 0) pop_flit(i);
    end
  endtask

  // Flags settle one cycle after the transfer edge.
  task automatic check_irq();
    logic [N_VIRT_CHN-1:0] exp;
    @(negedge clk_axi);
    exp = expected_irq();
    check_value("irq_vcs_o", 32'(irq_vcs_o), 32'(exp));
    check_value("irq_trig_o", 32'(irq_trig_o), 32'(|exp));
  endtask

  task automatic check_ports(input int vc, input logic exp_ready, input logic exp_valid);
    @(posedge clk_axi);
    in_vc_i  <= VC_W'(vc);
    out_vc_i <= VC_W'(vc);
    @(negedge clk_axi);
    check_value("in_ready_o", 32'(in_ready_o), 32'(exp_ready));
    check_value("out_valid_o", 32'(out_valid_o), 32'(exp_valid));
  endtask

  task automatic test_reset_identity();
    @(negedge clk_axi);
    check_value("csr_ack_o", 32'(csr_ack_o), '0);
    check_value("irq_vcs_o", 32'(irq_vcs_o), '0);
    check_value("irq_trig_o", 32'(irq_trig_o), '0);
    check_read(NOC_VERSION, NOC_VERSION_LABEL, 1'b0);
    check_read(ROUTER_ROW_X_ID, 32'd2, 1'b0);
    check_read(ROUTER_COL_Y_ID, 32'd1, 1'b0);
    check_read(IRQ_RD_STATUS, '0, 1'b0);
    check_read(IRQ_RD_MUX, '0, 1'b0);
    check_read(IRQ_RD_MASK, '1, 1'b0);
    finish_test("reset_identity");
  endtask

  task automatic test_errors();
    check_write(NOC_VERSION, 32'h1111_1111, 1'b1);
    check_write(ROUTER_ROW_X_ID, 32'h2222_2222, 1'b1);
    check_write(ROUTER_COL_Y_ID, 32'h3333_3333, 1'b1);
    check_write(IRQ_RD_STATUS, 32'h4444_4444, 1'b1);
    check_write(8'h18, 32'h5555_5555, 1'b1);
    check_read(8'h18, '0, 1'b1);
    // The failed writes must leave the interrupt setup alone.
    check_read(IRQ_RD_MUX, '0, 1'b0);
    check_read(IRQ_RD_MASK, '1, 1'b0);
    finish_test("errors");
  endtask

  task automatic test_reg_writes();
    // Only the two mode bits of the mux register are kept.
    check_write(IRQ_RD_MUX, 32'hFFFF_FFFE, 1'b0);
    check_read(IRQ_RD_MUX, 32'h0000_0002, 1'b0);
    check_write(IRQ_RD_MASK, 32'hA5C3_0F96, 1'b0);
    check_read(IRQ_RD_MASK, 32'hA5C3_0F96, 1'b0);
    set_irq_config(IRQ_NOT_EMPTY, '1);
    check_read(IRQ_RD_MUX, '0, 1'b0);
    check_read(IRQ_RD_MASK, '1, 1'b0);
    finish_test("reg_writes");
  endtask

  task automatic test_buffers_default();
    check_irq();
    repeat (2) begin
      push_flit(2);
      check_irq();
    end
    repeat (BUFF_DEPTH) begin
      push_flit(0);
      check_irq();
    end
    check_read(IRQ_RD_STATUS, nonempty_map(), 1'b0);
    // Channel 3 has no buffer behind it.
    check_ports(0, 1'b0, 1'b1);
    check_ports(1, 1'b1, 1'b0);
    check_ports(2, 1'b1, 1'b1);
    check_ports(3, 1'b0, 1'b0);
    while (model_q[0].size() != 0) begin
      pop_flit(0);
      check_irq();
    end
    while (model_q[2].size() != 0) begin
      pop_flit(2);
      check_irq();
    end
    check_read(IRQ_RD_STATUS, nonempty_map(), 1'b0);
    finish_test("buffers_default");
  endtask

  task automatic test_masked_modes();
    set_irq_config(IRQ_EMPTY_MASKED, 32'b100);
    push_flit(0);
    push_flit(2);
    check_irq();
    repeat (BUFF_DEPTH - 1) push_flit(0);
    push_flit(1);
    check_irq();
    set_irq_config(IRQ_FULL_MASKED, 32'b011);
    check_irq();
    set_irq_config(IRQ_FULL_MASKED, 32'b110);
    check_irq();
    drain_all();
    check_irq();
    finish_test("masked_modes");
  endtask

  task automatic test_ocup_cmp();
    set_irq_config(IRQ_OCUP_CMP, 32'd2);
    check_irq();
    repeat (BUFF_DEPTH) begin
      push_flit(1);
      check_irq();
    end
    push_flit(0);
    check_irq();
    while (model_q[1].size() != 0) begin
      pop_flit(1);
      check_irq();
    end
    drain_all();
    check_irq();
    set_irq_config(IRQ_NOT_EMPTY, '1);
    finish_test("ocup_cmp");
  endtask

  initial begin
    seed            = 32'hbf71_5cd5;
    err_count       = 0;
    check_count     = 0;
    test_start_errs = 0;
    cur_mode        = IRQ_NOT_EMPTY;
    cur_mask        = '1;
    arst_axi        = 1'b1;
    csr_req_i       = 1'b0;
    csr_wr_i        = 1'b0;
    csr_addr_i      = '0;
    csr_wdata_i     = '0;
    in_valid_i      = 1'b0;
    in_vc_i         = '0;
    in_data_i       = '0;
    out_vc_i        = '0;
    out_ready_i     = 1'b0;
    repeat (5) @(posedge clk_axi);
    arst_axi <= 1'b0;
    test_reset_identity();
    test_errors();
    test_reg_writes();
    test_buffers_default();
    test_masked_modes();
    test_ocup_cmp();
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: hdl/noc_csr_top.sv
/*
  Status and interrupt block of a router network interface.
  Joins the register file, the per channel read buffers and the
  interrupt combiner.
*/
module noc_csr_top import noc_csr_pkg::*; #(
  parameter int unsigned ROUTER_X_ID = 0,
  parameter int unsigned ROUTER_Y_ID = 0
) (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  // Register access port.
  input  logic                  csr_req_i,
  input  logic                  csr_wr_i,
  input  logic [31:0]           csr_addr_i,
  input  logic [31:0]           csr_wdata_i,
  output logic                  csr_ack_o,
  output logic [31:0]           csr_rdata_o,
  output logic                  csr_err_o,
  // Flit input.
  input  logic                  in_valid_i,
  input  logic [VC_W-1:0]       in_vc_i,
  input  logic [FLIT_W-1:0]     in_data_i,
  output logic                  in_ready_o,
  // Flit output.
  input  logic [VC_W-1:0]       out_vc_i,
  input  logic                  out_ready_i,
  output logic                  out_valid_o,
  output logic [FLIT_W-1:0]     out_data_o,
  // Interrupts.
  output logic [N_VIRT_CHN-1:0] irq_vcs_o,
  output logic                  irq_trig_o
);

  // Interrupt configuration from the register file.
  irq_mode_t   irq_mode;
  logic [31:0] irq_mask;

  // Buffer status.
  logic [N_VIRT_CHN-1:0]             empty;
  logic [N_VIRT_CHN-1:0]             full;
  logic [N_VIRT_CHN-1:0][OCUP_W-1:0] ocup;
  logic [N_VIRT_CHN-1:0]             nonempty;

  csr_regfile #(
    .ROUTER_X_ID (ROUTER_X_ID),
    .ROUTER_Y_ID (ROUTER_Y_ID)
  ) u_csr_regfile (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .csr_req_i   (csr_req_i),
    .csr_wr_i    (csr_wr_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_ack_o   (csr_ack_o),
    .csr_rdata_o (csr_rdata_o),
    .csr_err_o   (csr_err_o),
    .nonempty_i  (nonempty),
    .irq_mode_o  (irq_mode),
    .irq_mask_o  (irq_mask)
  );

  vc_rd_buffers u_vc_rd_buffers (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .in_valid_i  (in_valid_i),
    .in_vc_i     (in_vc_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_vc_i    (out_vc_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .empty_o     (empty),
    .full_o      (full),
    .ocup_o      (ocup)
  );

  // The combiner also feeds the status register with the non-empty map.
  irq_combiner u_irq_combiner (
    .irq_mode_i  (irq_mode),
    .irq_mask_i  (irq_mask),
    .empty_i     (empty),
    .full_i      (full),
    .ocup_i      (ocup),
    .nonempty_o  (nonempty),
    .irq_vcs_o   (irq_vcs_o),
    .irq_trig_o  (irq_trig_o)
  );

endmodule

// File: hdl/irq_combiner.sv
/*
  Interrupt combiner.
  Merges the interrupt mode and mask with the buffer flags into one
  interrupt per channel and a summary trigger, and provides the
  non-empty bitmap shown in the status register.
*/
module irq_combiner import noc_csr_pkg::*; (
  input  irq_mode_t                         irq_mode_i,
  input  logic [31:0]                       irq_mask_i,
  input  logic [N_VIRT_CHN-1:0]             empty_i,
  input  logic [N_VIRT_CHN-1:0]             full_i,
  input  logic [N_VIRT_CHN-1:0][OCUP_W-1:0] ocup_i,
  output logic [N_VIRT_CHN-1:0]             nonempty_o,
  output logic [N_VIRT_CHN-1:0]             irq_vcs_o,
  output logic                              irq_trig_o
);

  // A channel holding at least one flit.
  assign nonempty_o = ~empty_i;

  // Per channel interrupt source selection.
  // The logic is purely combinational, so interrupts follow the flags
  // and the registers with no extra delay.
  always_comb begin
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      case (irq_mode_i)
        IRQ_NOT_EMPTY: begin
          irq_vcs_o[i] = nonempty_o[i];
        end
        IRQ_EMPTY_MASKED: begin
          irq_vcs_o[i] = nonempty_o[i] && irq_mask_i[i];
        end
        IRQ_FULL_MASKED: begin
          irq_vcs_o[i] = full_i[i] && irq_mask_i[i];
        end
        IRQ_OCUP_CMP: begin
          // Here the whole mask word acts as an occupancy threshold.
          irq_vcs_o[i] = (32'(ocup_i[i]) >= irq_mask_i);
        end
        default: begin
          // Fall back to the reset behaviour.
          irq_vcs_o[i] = nonempty_o[i];
        end
      endcase
    end
  end

  // Any channel interrupt raises the summary line.
  assign irq_trig_o = |irq_vcs_o;

endmodule

// File: hdl/vc_rd_buffers.sv
/*
  Per virtual channel read buffers.
  Stores flits arriving from the network in one circular FIFO per
  channel, lets the host pop them first-word-fall-through and
  reports empty, full and occupancy for every channel.
*/
module vc_rd_buffers import noc_csr_pkg::*; (
  input  logic                              clk_axi,
  input  logic                              arst_axi,
  // Flit input from the network.
  input  logic                              in_valid_i,
  input  logic [VC_W-1:0]                   in_vc_i,
  input  logic [FLIT_W-1:0]                 in_data_i,
  output logic                              in_ready_o,
  // Flit output towards the host.
  input  logic [VC_W-1:0]                   out_vc_i,
  input  logic                              out_ready_i,
  output logic                              out_valid_o,
  output logic [FLIT_W-1:0]                 out_data_o,
  // Per channel status.
  output logic [N_VIRT_CHN-1:0]             empty_o,
  output logic [N_VIRT_CHN-1:0]             full_o,
  output logic [N_VIRT_CHN-1:0][OCUP_W-1:0] ocup_o
);

  // Flit storage, one row per channel.
  logic [FLIT_W-1:0] mem [N_VIRT_CHN][BUFF_DEPTH];

  // Pointers and fill counts.
  logic [N_VIRT_CHN-1:0][PTR_W-1:0] wr_ptr_ff;
  logic [N_VIRT_CHN-1:0][PTR_W-1:0] rd_ptr_ff;
  logic [N_VIRT_CHN-1:0][CNT_W-1:0] cnt_ff;

  // Per channel transfer strobes for this cycle.
  logic [N_VIRT_CHN-1:0] push;
  logic [N_VIRT_CHN-1:0] pop;

  // Status flags come straight from the registered counts.
  // They therefore move one cycle after the push or pop edge.
  always_comb begin
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      empty_o[i] = (cnt_ff[i] == '0);
      full_o[i]  = (cnt_ff[i] == CNT_W'(BUFF_DEPTH));
      ocup_o[i]  = OCUP_W'(cnt_ff[i]);
    end
  end

  // Channel selection on both sides.
  // A channel number with no buffer behind it matches no loop index,
  // so it is never ready on input and never valid on output.
  always_comb begin
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    out_data_o  = '0;
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      if (in_vc_i == VC_W'(i)) begin
        in_ready_o = !full_o[i];
      end
      if (out_vc_i == VC_W'(i)) begin
        out_valid_o = !empty_o[i];
        // Head of the queue is shown before it is popped.
        out_data_o  = mem[i][rd_ptr_ff[i]];
      end
    end
  end

  // Transfers happen only where valid and ready meet.
  always_comb begin
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      push[i] = in_valid_i && in_ready_o && (in_vc_i == VC_W'(i));
      pop[i]  = out_valid_o && out_ready_i && (out_vc_i == VC_W'(i));
    end
  end

  // Payload write.
  always_ff @(posedge clk_axi) begin
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      if (push[i]) begin
        mem[i][wr_ptr_ff[i]] <= in_data_i;
      end
    end
  end

  // Pointer and count update.
  // A push and a pop on the same channel in one cycle cancel in the count.
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr_ff <= '0;
      rd_ptr_ff <= '0;
      cnt_ff    <= '0;
    end else begin
      for (int i = 0; i < N_VIRT_CHN; i++) begin
        if (push[i]) begin
          wr_ptr_ff[i] <= (wr_ptr_ff[i] == PTR_W'(BUFF_DEPTH - 1)) ?
                          '0 : wr_ptr_ff[i] + 1'b1;
        end
        if (pop[i]) begin
          rd_ptr_ff[i] <= (rd_ptr_ff[i] == PTR_W'(BUFF_DEPTH - 1)) ?
                          '0 : rd_ptr_ff[i] + 1'b1;
        end
        case ({push[i], pop[i]})
          2'b10:   cnt_ff[i] <= cnt_ff[i] + 1'b1;
          2'b01:   cnt_ff[i] <= cnt_ff[i] - 1'b1;
          default: cnt_ff[i] <= cnt_ff[i];
        endcase
      end
    end
  end

endmodule

// File: hdl/csr_regfile.sv
/*
  Control and status register file of the network interface.
  Serves single-word four-phase req/ack accesses, returns the version,
  router position and buffer status words, and holds the interrupt
  mode and mask registers used by the interrupt combiner.
*/
module csr_regfile import noc_csr_pkg::*; #(
  parameter int unsigned ROUTER_X_ID = 0,
  parameter int unsigned ROUTER_Y_ID = 0
) (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  // Four-phase register access port.
  input  logic                  csr_req_i,
  input  logic                  csr_wr_i,
  input  logic [31:0]           csr_addr_i,
  input  logic [31:0]           csr_wdata_i,
  output logic                  csr_ack_o,
  output logic [31:0]           csr_rdata_o,
  output logic                  csr_err_o,
  // Buffer status seen through the status register.
  input  logic [N_VIRT_CHN-1:0] nonempty_i,
  // Interrupt configuration for the combiner.
  output irq_mode_t             irq_mode_o,
  output logic [31:0]           irq_mask_o
);

  // Handshake and response registers.
  logic        ack_ff;
  logic [31:0] rdata_ff;
  logic        err_ff;

  // Interrupt configuration registers.
  irq_mode_t   irq_mode_ff;
  logic [31:0] irq_mask_ff;

  // Decode results for the current request.
  logic [31:0] offset;
  csr_addr_t   reg_sel;
  logic        in_window;
  logic [31:0] rd_data;
  logic        rd_err;
  logic        wr_err;
  logic        sel_mode;
  logic        sel_mask;

  // A new access starts when req is seen high while ack is still low.
  // The host only raises req after ack has dropped, so this is a single edge.
  logic        start;

  assign start = csr_req_i && !ack_ff;

  // Address decode.
  // The base address is removed first and only the low byte names a register.
  // Any offset with upper bits set lies outside the window and is unknown.
  always_comb begin
    offset    = csr_addr_i - CSR_BASE_ADDR;
    reg_sel   = csr_addr_t'(offset[7:0]);
    in_window = (offset[31:8] == '0);
    rd_data   = '0;
    rd_err    = 1'b0;
    sel_mode  = 1'b0;
    sel_mask  = 1'b0;

    if (!in_window) begin
      rd_err = 1'b1;
    end else begin
      case (reg_sel)
        NOC_VERSION:     rd_data = NOC_VERSION_LABEL;
        ROUTER_ROW_X_ID: rd_data = 32'(ROUTER_X_ID);
        ROUTER_COL_Y_ID: rd_data = 32'(ROUTER_Y_ID);
        // One bit per channel, set while that channel holds a flit.
        IRQ_RD_STATUS:   rd_data = 32'(nonempty_i);
        IRQ_RD_MUX: begin
          // Only the two mode bits exist, the rest read as zero.
          rd_data  = 32'(irq_mode_ff);
          sel_mode = 1'b1;
        end
        IRQ_RD_MASK: begin
          rd_data  = irq_mask_ff;
          sel_mask = 1'b1;
        end
        default:         rd_err = 1'b1;
      endcase
    end

    // Only the mux and mask registers accept writes.
    // Every other offset, known or not, answers a write with an error.
    wr_err = !(sel_mode || sel_mask);
  end

  // Four-phase handshake.
  // Ack rises on the edge that starts an access and falls on the first
  // edge that sees req low. Read data and error are captured with the
  // rising ack and held stable until the next access.
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      ack_ff   <= 1'b0;
      rdata_ff <= '0;
      err_ff   <= 1'b0;
    end else begin
      if (start) begin
        ack_ff <= 1'b1;
        if (csr_wr_i) begin
          // Writes never return data.
          rdata_ff <= '0;
          err_ff   <= wr_err;
        end else begin
          rdata_ff <= rd_data;
          err_ff   <= rd_err;
        end
      end else if (!csr_req_i) begin
        ack_ff <= 1'b0;
      end
    end
  end

  // Mode and mask registers.
  // A write lands on the same edge that raises ack.
  // After reset every channel is enabled in the not-empty mode.
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      irq_mode_ff <= IRQ_NOT_EMPTY;
      irq_mask_ff <= '1;
    end else if (start && csr_wr_i) begin
      if (sel_mode) begin
        irq_mode_ff <= irq_mode_t'(csr_wdata_i[1:0]);
      end
      if (sel_mask) begin
        irq_mask_ff <= csr_wdata_i;
      end
    end
  end

  assign csr_ack_o   = ack_ff;
  assign csr_rdata_o = rdata_ff;
  assign csr_err_o   = err_ff;

  assign irq_mode_o  = irq_mode_ff;
  assign irq_mask_o  = irq_mask_ff;

endmodule

// File: hdl/noc_csr_pkg.sv
/*
  NoC network interface status and interrupt package.
  Holds the channel count, data widths, register window base,
  register offsets and the interrupt source encodings shared by
  the register file, the read buffers and the interrupt combiner.
*/
package noc_csr_pkg;

  // Number of virtual channels served by this network interface.
  localparam int N_VIRT_CHN = 3;

  // Width of the channel select fields on the flit ports.
  localparam int VC_W = 2;

  // Width of one flit payload word.
  localparam int FLIT_W = 32;

  // Number of flits each per-channel read buffer can hold.
  localparam int BUFF_DEPTH = 4;

  // Buffer pointer width and occupancy counter width.
  // The counter needs one extra state to tell full from empty.
  localparam int PTR_W = $clog2(BUFF_DEPTH);
  localparam int CNT_W = $clog2(BUFF_DEPTH + 1);

  // Width of the occupancy value reported to the combiner.
  localparam int OCUP_W = 16;

  // Byte address where the register window starts.
  // All register offsets below are relative to this address.
  localparam logic [31:0] CSR_BASE_ADDR = 32'h0000_1000;

  // Constant returned by a read of the version register.
  localparam logic [31:0] NOC_VERSION_LABEL = 32'h4E43_0102;

  // Register offsets inside the window.
  // Anything not listed here decodes as an unknown register.
  typedef enum logic [7:0] {
    NOC_VERSION     = 8'h00,
    ROUTER_ROW_X_ID = 8'h04,
    ROUTER_COL_Y_ID = 8'h08,
    IRQ_RD_STATUS   = 8'h0C,
    IRQ_RD_MUX      = 8'h10,
    IRQ_RD_MASK     = 8'h14
  } csr_addr_t;

  // Interrupt source selection held in the mux register.
  // IRQ_NOT_EMPTY fires on any non-empty channel and ignores the mask.
  // IRQ_EMPTY_MASKED fires on a non-empty channel whose mask bit is set.
  // IRQ_FULL_MASKED fires on a full channel whose mask bit is set.
  // IRQ_OCUP_CMP fires when the channel occupancy reaches the mask value.
  typedef enum logic [1:0] {
    IRQ_NOT_EMPTY    = 2'd0,
    IRQ_EMPTY_MASKED = 2'd1,
    IRQ_FULL_MASKED  = 2'd2,
    IRQ_OCUP_CMP     = 2'd3
  } irq_mode_t;

endpackage
